/* rtl/brisc_pkg.sv */
package brisc_pkg;

  // Core datapath width
  localparam int unsigned XLEN = 32;

  // Byte address width seen by the memory stage
  localparam int unsigned ADDRESS_WIDTH = 16;

  // One data word as it moves through the stage
  typedef logic [XLEN-1:0] word_t;

  // Byte address, low bits select the lane within a word
  typedef logic [ADDRESS_WIDTH-1:0] addr_t;

  // Operation presented to the memory stage this cycle
  typedef enum logic [1:0] {
    IS_LOAD  = 2'd0,
    IS_STORE = 2'd1,
    // ALU instruction, the stage is free to drain one entry
    OTHER    = 2'd2
  } stb_ctrl_e;

  // Access size, byte loads zero-extend
  typedef enum logic {
    B = 1'b0,
    W = 1'b1
  } data_size_e;

endpackage

/* rtl/dmem_pkg.sv */
package dmem_pkg;

  // Store buffer depth unless the top level overrides it
  localparam int unsigned DEF_STB_ENTRIES = 4;

  // Data memory depth in words
  localparam int unsigned DEF_MEM_WORDS = 256;

  // Lane geometry of a memory word
  localparam int unsigned BYTE_WIDTH = 8;
  localparam int unsigned BYTES_PER_WORD = 4;

  // Byte address bits below the word index
  localparam int unsigned WORD_SHIFT = $clog2(BYTES_PER_WORD);

  // One bit per byte lane on a write
  typedef logic [BYTES_PER_WORD-1:0] byte_en_t;

endpackage

/* rtl/store_buffer.sv */
`timescale 1ns/1ps

module store_buffer
  import brisc_pkg::*;
  import dmem_pkg::*;
#(
  parameter int unsigned NUM_ENTRIES = DEF_STB_ENTRIES
) (
  input  logic       clk,
  input  logic       reset,
  input  logic       enable,
  input  stb_ctrl_e  stb_ctrl,
  input  addr_t      addr,
  input  word_t      write_data,
  input  data_size_e data_size,
  output logic       mem_write,
  output addr_t      mem_addr,
  output word_t      mem_data,
  output data_size_e mem_size,
  output logic       fwd_hit,
  output word_t      fwd_data,
  output data_size_e fwd_size,
  output logic       stall
);

  localparam int unsigned PTR_W = (NUM_ENTRIES > 1) ? $clog2(NUM_ENTRIES) : 1;

  // Entry payload, only the valid bits are reset
  addr_t            entry_addr [NUM_ENTRIES];
  word_t            entry_data [NUM_ENTRIES];
  data_size_e       entry_size [NUM_ENTRIES];
  logic [NUM_ENTRIES-1:0] entry_valid;

  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W:0]   count;

  logic             is_load;
  logic             is_store;
  logic             is_other;
  logic             full;
  logic             empty;
  logic             fwd_match;
  logic [PTR_W-1:0] fwd_idx;
  logic             byte_overlap;
  logic             load_overlap;
  logic             drain;
  logic             accept;

  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(NUM_ENTRIES - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign is_load  = (stb_ctrl == IS_LOAD);
  assign is_store = (stb_ctrl == IS_STORE);
  assign is_other = (stb_ctrl == OTHER);
  assign full     = (count == NUM_ENTRIES);
  assign empty    = (count == 0);

  // Walk oldest to youngest so the last match is the youngest one
  always_comb begin
    int unsigned idx;
    idx = 0;
    fwd_match = 1'b0;
    fwd_idx = '0;
    byte_overlap = 1'b0;
    for (int unsigned i = 0; i < NUM_ENTRIES; i++) begin
      idx = (rd_ptr + i) % NUM_ENTRIES;
      if (entry_valid[idx] &&
          entry_addr[idx][ADDRESS_WIDTH-1:WORD_SHIFT] == addr[ADDRESS_WIDTH-1:WORD_SHIFT]) begin
        if (entry_size[idx] == W) begin
          fwd_match = 1'b1;
          fwd_idx = PTR_W'(idx);
        end else begin
          byte_overlap = 1'b1;
          // A byte entry covers only a byte load of that same byte
          if (data_size == B && entry_addr[idx] == addr) begin
            fwd_match = 1'b1;
            fwd_idx = PTR_W'(idx);
          end
        end
      end
    end
  end

  // Word load over a buffered byte, must drain before it can read memory
  assign load_overlap = is_load && (data_size == W) && byte_overlap;

  assign drain = (is_store && full) || (is_other && !empty) || load_overlap;

  // Never both in one cycle, a draining store finds the buffer full
  assign accept = is_store && !full && !drain;

  assign stall = (is_store && full) || load_overlap;

  // Oldest entry goes to memory
  assign mem_write = enable && drain;
  assign mem_addr  = entry_addr[rd_ptr];
  assign mem_data  = entry_data[rd_ptr];
  assign mem_size  = entry_size[rd_ptr];

  assign fwd_hit  = is_load && fwd_match;
  assign fwd_data = entry_data[fwd_idx];
  assign fwd_size = entry_size[fwd_idx];

  always_ff @(posedge clk) begin
    if (reset) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count <= '0;
      entry_valid <= '0;
    end else if (enable) begin
      if (drain) begin
        entry_valid[rd_ptr] <= 1'b0;
        rd_ptr <= next_ptr(rd_ptr);
        count <= count - 1'b1;
      end else if (accept) begin
        entry_valid[wr_ptr] <= 1'b1;
        wr_ptr <= next_ptr(wr_ptr);
        count <= count + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (enable && accept) begin
      entry_addr[wr_ptr] <= addr;
      entry_data[wr_ptr] <= write_data;
      entry_size[wr_ptr] <= data_size;
    end
  end

endmodule

/* rtl/data_memory.sv */
`timescale 1ns/1ps

module data_memory
  import brisc_pkg::*;
  import dmem_pkg::*;
#(
  parameter int unsigned MEM_WORDS = DEF_MEM_WORDS
) (
  input  logic       clk,
  input  logic       reset,
  input  logic       write,
  input  addr_t      write_addr,
  input  word_t      write_data,
  input  data_size_e write_size,
  input  addr_t      read_addr,
  output word_t      read_data
);

  localparam int unsigned INDEX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;

  word_t mem [MEM_WORDS];

  logic [INDEX_W-1:0]    write_index;
  logic [INDEX_W-1:0]    read_index;
  logic [WORD_SHIFT-1:0] write_offset;
  byte_en_t              byte_en;
  word_t                 lane_data;

  // Address bits above the memory depth alias
  assign write_index  = write_addr[WORD_SHIFT +: INDEX_W];
  assign read_index   = read_addr[WORD_SHIFT +: INDEX_W];
  assign write_offset = write_addr[WORD_SHIFT-1:0];

  // Lane mask and data alignment
  always_comb begin
    if (write_size == W) begin
      byte_en = '1;
      lane_data = write_data;
    end else begin
      byte_en = byte_en_t'(1) << write_offset;
      // Store data carries the byte in its low bits
      lane_data = word_t'(write_data[BYTE_WIDTH-1:0]) << (write_offset * BYTE_WIDTH);
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int unsigned i = 0; i < MEM_WORDS; i++) begin
        mem[i] <= '0;
      end
    end else if (write) begin
      for (int unsigned lane = 0; lane < BYTES_PER_WORD; lane++) begin
        if (byte_en[lane]) begin
          mem[write_index][lane*BYTE_WIDTH +: BYTE_WIDTH] <=
              lane_data[lane*BYTE_WIDTH +: BYTE_WIDTH];
        end
      end
    end
  end

  // Local memory, always hits
  assign read_data = mem[read_index];

endmodule

/* rtl/load_align.sv */
`timescale 1ns/1ps

module load_align
  import brisc_pkg::*;
  import dmem_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  logic       enable,
  input  stb_ctrl_e  stb_ctrl,
  input  addr_t      addr,
  input  data_size_e data_size,
  input  logic       stall,
  input  logic       fwd_hit,
  input  word_t      fwd_data,
  input  data_size_e fwd_size,
  input  word_t      mem_rd_data,
  output logic       load_valid,
  output word_t      load_data
);

  logic                  load_fire;
  word_t                 src_data;
  logic [BYTE_WIDTH-1:0] load_byte;
  word_t                 result;

  assign load_fire = enable && (stb_ctrl == IS_LOAD) && !stall;

  // Buffer wins over memory when it holds the youngest copy
  assign src_data = fwd_hit ? fwd_data : mem_rd_data;

  always_comb begin
    if (fwd_hit && fwd_size == B) begin
      // Byte entry keeps its byte unshifted
      load_byte = fwd_data[BYTE_WIDTH-1:0];
    end else begin
      load_byte = src_data[addr[WORD_SHIFT-1:0] * BYTE_WIDTH +: BYTE_WIDTH];
    end

    if (data_size == B) begin
      result = word_t'(load_byte);
    end else begin
      result = src_data;
    end
  end

  // One pulse per load, low again on any idle or disabled cycle
  always_ff @(posedge clk) begin
    if (reset) begin
      load_valid <= 1'b0;
    end else begin
      load_valid <= load_fire;
    end
  end

  always_ff @(posedge clk) begin
    if (load_fire) begin
      load_data <= result;
    end
  end

endmodule

/* rtl/mem_stage.sv */
`timescale 1ns/1ps

module mem_stage
  import brisc_pkg::*;
  import dmem_pkg::*;
#(
  parameter int unsigned NUM_ENTRIES = DEF_STB_ENTRIES,
  parameter int unsigned MEM_WORDS   = DEF_MEM_WORDS
) (
  input  logic       clk,
  input  logic       reset,
  input  logic       enable,
  input  stb_ctrl_e  stb_ctrl,
  input  addr_t      addr,
  input  word_t      write_data,
  input  data_size_e data_size,
  output logic       stall,
  output logic       load_valid,
  output word_t      load_data
);

  // Drain path to memory
  logic       mem_write;
  addr_t      mem_addr;
  word_t      mem_data;
  data_size_e mem_size;

  // Forward path to the load side
  logic       fwd_hit;
  word_t      fwd_data;
  data_size_e fwd_size;
  word_t      rd_data;

  store_buffer #(
    .NUM_ENTRIES(NUM_ENTRIES)
  ) u_store_buffer (
    .clk       (clk),
    .reset     (reset),
    .enable    (enable),
    .stb_ctrl  (stb_ctrl),
    .addr      (addr),
    .write_data(write_data),
    .data_size (data_size),
    .mem_write (mem_write),
    .mem_addr  (mem_addr),
    .mem_data  (mem_data),
    .mem_size  (mem_size),
    .fwd_hit   (fwd_hit),
    .fwd_data  (fwd_data),
    .fwd_size  (fwd_size),
    .stall     (stall)
  );

  data_memory #(
    .MEM_WORDS(MEM_WORDS)
  ) u_data_memory (
    .clk       (clk),
    .reset     (reset),
    .write     (mem_write),
    .write_addr(mem_addr),
    .write_data(mem_data),
    .write_size(mem_size),
    .read_addr (addr),
    .read_data (rd_data)
  );

  load_align u_load_align (
    .clk        (clk),
    .reset      (reset),
    .enable     (enable),
    .stb_ctrl   (stb_ctrl),
    .addr       (addr),
    .data_size  (data_size),
    .stall      (stall),
    .fwd_hit    (fwd_hit),
    .fwd_data   (fwd_data),
    .fwd_size   (fwd_size),
    .mem_rd_data(rd_data),
    .load_valid (load_valid),
    .load_data  (load_data)
  );

endmodule

/* dv/mem_stage_assertions.sv */
`timescale 1ns/1ps

module mem_stage_assertions #(
  parameter int unsigned NUM_ENTRIES = 4,
  parameter int unsigned PTR_W = 2
) (
  input logic                   clk,
  input logic                   reset,
  input logic                   enable,
  input logic                   mem_write,
  input logic [PTR_W:0]         count,
  input logic [PTR_W-1:0]       rd_ptr,
  input logic [PTR_W-1:0]       wr_ptr,
  input logic [NUM_ENTRIES-1:0] entry_valid
);

  // Occupancy bounded by the buffer depth
  assert property (@(posedge clk) disable iff (reset) count <= NUM_ENTRIES)
    else $error("Store buffer count above its depth");

  assert property (@(posedge clk) disable iff (reset) mem_write |-> count != 0)
    else $error("Memory write strobe with an empty store buffer");

  // Frozen while the stage is held off
  assert property (@(posedge clk) disable iff (reset)
      !enable |=> $stable(count) && $stable(rd_ptr) && $stable(wr_ptr) && $stable(entry_valid))
    else $error("Store buffer state changed while enable was low");

endmodule

/* dv/mem_stage_tb.sv */
`timescale 1ns/1ps

module mem_stage_tb
  import brisc_pkg::*;
  import dmem_pkg::*;
();

  localparam int unsigned CLK_PERIOD = 10;
  localparam int unsigned RESET_CYCLES = 5;
  localparam int unsigned CYCLES_PER_TEST = 20;
  localparam int unsigned EXTRA_CYCLES = 100;
  localparam string TEST_FILE = "dv/mem_stage_tests.txt";

  logic       clk;
  logic       reset;
  logic       enable;
  stb_ctrl_e  stb_ctrl;
  addr_t      addr;
  word_t      write_data;
  data_size_e data_size;
  logic       stall;
  logic       load_valid;
  word_t      load_data;

  // One element per line of the test file
  logic [31:0] test_op [$];
  logic [31:0] test_addr [$];
  logic [31:0] test_data [$];
  logic [31:0] test_size [$];
  logic [31:0] test_exp [$];

  // Reference occupancy of the store buffer, oldest first
  addr_t      model_addr [$];
  data_size_e model_size [$];

  // Expected value of the last completed load
  word_t      last_load;

  int unsigned check_count;
  int unsigned error_count;
  int unsigned current_test;
  bit          tests_loaded;

  mem_stage #(
    .NUM_ENTRIES(DEF_STB_ENTRIES),
    .MEM_WORDS  (DEF_MEM_WORDS)
  ) dut_i (
    .clk       (clk),
    .reset     (reset),
    .enable    (enable),
    .stb_ctrl  (stb_ctrl),
    .addr      (addr),
    .write_data(write_data),
    .data_size (data_size),
    .stall     (stall),
    .load_valid(load_valid),
    .load_data (load_data)
  );

  bind store_buffer mem_stage_assertions #(
    .NUM_ENTRIES(NUM_ENTRIES),
    .PTR_W      (PTR_W)
  ) u_sb_assertions (
    .clk        (clk),
    .reset      (reset),
    .enable     (enable),
    .mem_write  (mem_write),
    .count      (count),
    .rd_ptr     (rd_ptr),
    .wr_ptr     (wr_ptr),
    .entry_valid(entry_valid)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  task automatic check_value(input string name, input word_t actual, input word_t expected);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("CHECK FAILED: %s = 0x%08h, expected 0x%08h (test %0d, time %0t)",
               name, actual, expected, current_test, $time);
    end
  endtask

  task automatic load_tests();
    int          fd;
    int          fields;
    string       line;
    logic [31:0] op;
    logic [31:0] a;
    logic [31:0] d;
    logic [31:0] s;
    logic [31:0] e;
    fd = $fopen(TEST_FILE, "r");
    if (fd == 0) begin
      error_count++;
      $display("Could not open the test file %s", TEST_FILE);
    end else begin
      while ($fgets(line, fd) != 0) begin
        if (line.len() == 0 || line[0] == "#") begin
          continue;
        end
        fields = $sscanf(line, "%h %h %h %h %h", op, a, d, s, e);
        if (fields == 5) begin
          test_op.push_back(op);
          test_addr.push_back(a);
          test_data.push_back(d);
          test_size.push_back(s);
          test_exp.push_back(e);
        end else if (fields > 0) begin
          error_count++;
          $display("Malformed line in the test file: %s", line);
        end
      end
      $fclose(fd);
    end
    tests_loaded = 1'b1;
  endtask

  // Held cycles for one operation under the drain and stall rules
  function automatic int unsigned predict_holds(input int unsigned idx);
    addr_t       a;
    data_size_e  s;
    int unsigned holds;
    a = addr_t'(test_addr[idx]);
    s = data_size_e'(test_size[idx][0]);
    holds = 0;
    if (test_op[idx] == 0) begin
      // Word load waits until the youngest byte store in its word is gone
      if (s == W) begin
        foreach (model_addr[k]) begin
          if (model_size[k] == B &&
              model_addr[k][ADDRESS_WIDTH-1:WORD_SHIFT] == a[ADDRESS_WIDTH-1:WORD_SHIFT]) begin
            holds = k + 1;
          end
        end
      end
      repeat (holds) begin
        void'(model_addr.pop_front());
        void'(model_size.pop_front());
      end
    end else if (test_op[idx] == 1) begin
      if (model_addr.size() == DEF_STB_ENTRIES) begin
        holds = 1;
        void'(model_addr.pop_front());
        void'(model_size.pop_front());
      end
      model_addr.push_back(a);
      model_size.push_back(s);
    end else if (model_addr.size() != 0) begin
      void'(model_addr.pop_front());
      void'(model_size.pop_front());
    end
    return holds;
  endfunction

  // Random operations with enable low that the stage must ignore
  task automatic idle_gap(input int unsigned cycles);
    repeat (cycles) begin
      enable = 1'b0;
      stb_ctrl = stb_ctrl_e'(2'($urandom % 3));
      addr = addr_t'($urandom);
      write_data = $urandom;
      data_size = data_size_e'(1'($urandom % 2));
      @(posedge clk);
      #1;
      check_value("load_valid", word_t'(load_valid), '0);
      if (!$isunknown(last_load)) begin
        check_value("load_data", load_data, last_load);
      end
    end
  endtask

  task automatic apply_op(input int unsigned idx);
    logic        expect_load;
    int unsigned expect_holds;
    int unsigned held;
    expect_load = (test_op[idx] == 0);
    expect_holds = predict_holds(idx);
    held = 0;
    enable = 1'b1;
    stb_ctrl = stb_ctrl_e'(test_op[idx][1:0]);
    addr = addr_t'(test_addr[idx]);
    write_data = test_data[idx];
    data_size = data_size_e'(test_size[idx][0]);
    // Inputs stay put while the buffer drains
    @(negedge clk);
    while (stall) begin
      held++;
      @(negedge clk);
    end
    check_value("stall cycles", word_t'(held), word_t'(expect_holds));
    @(posedge clk);
    #1;
    check_value("load_valid", word_t'(load_valid), word_t'(expect_load));
    if (expect_load) begin
      check_value("load_data", load_data, test_exp[idx]);
      last_load = test_exp[idx];
    end
  endtask

  initial begin
    clk = 1'b0;
    reset = 1'b1;
    enable = 1'b0;
    stb_ctrl = OTHER;
    addr = '0;
    write_data = '0;
    data_size = W;
    last_load = 'x;
    check_count = 0;
    error_count = 0;
    current_test = 0;
    tests_loaded = 1'b0;
    void'($urandom(30170));
    load_tests();
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    reset = 1'b0;
    check_value("stall", word_t'(stall), '0);
    check_value("load_valid", word_t'(load_valid), '0);
    for (int unsigned i = 0; i < test_op.size(); i++) begin
      current_test = i + 1;
      idle_gap($urandom % 4);
      apply_op(i);
    end
    enable = 1'b0;
    $display("Checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  // Budget grows with the number of test lines
  initial begin
    int unsigned limit;
    wait (tests_loaded);
    limit = test_op.size() * CYCLES_PER_TEST + EXTRA_CYCLES;
    repeat (limit) @(posedge clk);
    $display("Timeout: the run did not finish within %0d cycles", limit);
    $display("Simulation failed");
    $finish;
  end

endmodule

/* dv/mem_stage_tests.txt */
# Columns: op addr data size expected, all hex
# op 0 load, 1 store, 2 other; size 0 byte, 1 word; expected is checked on loads only
1 0020 deadbeef 1 00000000
2 0000 00000000 1 00000000
0 0020 00000000 1 deadbeef
1 0010 11223344 1 00000000
0 0010 00000000 1 11223344
0 0012 00000000 0 00000022
1 0021 000000a5 0 00000000
0 0021 00000000 0 000000a5
0 0020 00000000 0 000000ef
1 0030 cafef00d 1 00000000
1 0030 0badbeef 1 00000000
0 0030 00000000 1 0badbeef
0 0033 00000000 0 0000000b
1 0040 55667788 1 00000000
0 0010 00000000 1 11223344
0 0021 00000000 0 000000a5
0 0023 00000000 0 000000de
0 0020 00000000 1 deada5ef
1 0050 aabbccdd 1 00000000
2 0000 00000000 1 00000000
2 0000 00000000 1 00000000
0 0030 00000000 1 0badbeef
2 0000 00000000 1 00000000
2 0000 00000000 1 00000000
2 0000 00000000 1 00000000
0 0040 00000000 1 55667788
0 0052 00000000 0 000000bb
1 0060 00000011 0 00000000
1 0070 01020304 1 00000000
1 0063 00000099 0 00000000
0 0062 00000000 0 00000000
0 0060 00000000 1 99000011
0 0070 00000000 1 01020304
0 0071 00000000 0 00000003
1 0080 000000ee 0 00000000
1 0080 a1b2c3d4 1 00000000
0 0080 00000000 1 a1b2c3d4
0 0081 00000000 0 000000c3
2 0000 00000000 1 00000000
0 0080 00000000 1 a1b2c3d4
1 0090 10000001 1 00000000
1 0094 20000002 1 00000000
1 0098 30000003 1 00000000
1 009c 40000004 1 00000000
1 00a0 50000005 1 00000000
0 0090 00000000 1 10000001
0 0094 00000000 1 20000002
0 0098 00000000 1 30000003
0 009f 00000000 0 00000040
0 00a0 00000000 1 50000005

/* files.f */
rtl/brisc_pkg.sv
rtl/dmem_pkg.sv
rtl/store_buffer.sv
rtl/data_memory.sv
rtl/load_align.sv
rtl/mem_stage.sv
dv/mem_stage_assertions.sv
dv/mem_stage_tb.sv
